//--- src/memStagePkg.sv
package memStagePkg;

    // datapath and RAM geometry
    localparam int DATA_W    = 32;
    localparam int MEM_AW    = 8;
    localparam int MEM_WORDS = 1 << MEM_AW;

    // memory operation of one slot
    typedef enum logic [3:0] {
        MOP_NONE,
        MOP_LB,
        MOP_LBU,
        MOP_LH,
        MOP_LHU,
        MOP_LW,
        MOP_SB,
        MOP_SH,
        MOP_SW
    } memOp_e;

    // fault reported by the external TLB
    typedef enum logic [1:0] {
        TLB_NONE,
        TLB_REFILL,
        TLB_INVALID
    } tlbExc_e;

    // per-slot exception result
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADEL,
        EXC_ADES,
        EXC_TLBL,
        EXC_TLBS,
        EXC_SQUASHED
    } excCode_e;

    // one slot's request from memAccess to dbusSequencer
    typedef struct packed {
        logic                  doAccess;
        logic                  isLoad;
        memOp_e                op;
        logic [DATA_W-1:0]     addr;
        logic [DATA_W-1:0]     wdata;
        logic [DATA_W/8-1:0]   strobe;
        logic                  regWrite;
        logic [4:0]            rdst;
    } memReq_t;

    // sequencer FSM
    typedef enum logic [1:0] {
        IDLE,
        BUS_REQ,
        BUS_RELEASE,
        DONE
    } seqState_e;

endpackage

//--- src/dbusIf.sv
`timescale 1ns/1ps

interface dbusIf;
    import memStagePkg::*;

    // master side
    logic                req;
    logic [DATA_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] strobe;

    // slave side, rdata valid while ack is high
    logic                ack;
    logic [DATA_W-1:0]   rdata;

    modport master (
        output req, addr, wdata, strobe,
        input  ack, rdata
    );

    modport slave (
        input  req, addr, wdata, strobe,
        output ack, rdata
    );

endinterface

//--- src/storeAlign.sv
`timescale 1ns/1ps

module storeAlign (
    input  memStagePkg::memOp_e                 op,
    input  logic [1:0]                          byteOffset,
    input  logic [memStagePkg::DATA_W-1:0]      storeData,
    output logic [memStagePkg::DATA_W-1:0]      wdata,
    output logic [memStagePkg::DATA_W/8-1:0]    strobe
);
    import memStagePkg::*;

    always_comb begin
        wdata  = storeData;
        strobe = '0;
        case (op)
            MOP_SB: begin
                // same byte in every lane, strobe picks one
                wdata  = {4{storeData[7:0]}};
                strobe = 4'b0001 << byteOffset;
            end
            MOP_SH: begin
                wdata  = {2{storeData[15:0]}};
                strobe = byteOffset[1] ? 4'b1100 : 4'b0011;
            end
            MOP_SW: begin
                strobe = 4'b1111;
            end
            // loads and no-ops write nothing
            default: begin
                strobe = '0;
            end
        endcase
    end

endmodule

//--- src/loadExtend.sv
`timescale 1ns/1ps

module loadExtend (
    input  memStagePkg::memOp_e             op,
    input  logic [1:0]                      byteOffset,
    input  logic [memStagePkg::DATA_W-1:0]  rdata,
    output logic [memStagePkg::DATA_W-1:0]  loadValue
);
    import memStagePkg::*;

    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    // lane select from low address bits
    assign byteLane = rdata[{byteOffset, 3'b000} +: 8];
    assign halfLane = byteOffset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (op)
            MOP_LB: begin
                loadValue = {{24{byteLane[7]}}, byteLane};
            end
            MOP_LBU: begin
                loadValue = {24'h0, byteLane};
            end
            MOP_LH: begin
                loadValue = {{16{halfLane[15]}}, halfLane};
            end
            MOP_LHU: begin
                loadValue = {16'h0, halfLane};
            end
            MOP_LW: begin
                loadValue = rdata;
            end
            default: begin
                loadValue = '0;
            end
        endcase
    end

endmodule

//--- src/memAccess.sv
`timescale 1ns/1ps

module memAccess (
    input  memStagePkg::memOp_e [1:0]               slotOp,
    input  logic [1:0][memStagePkg::DATA_W-1:0]     slotAddr,
    input  logic [1:0][memStagePkg::DATA_W-1:0]     slotStoreData,
    input  logic [1:0][4:0]                         slotRdst,
    input  memStagePkg::tlbExc_e [1:0]              slotTlbExc,
    output memStagePkg::memReq_t [1:0]              req,
    output memStagePkg::excCode_e [1:0]             excCode,
    output logic                                    excp
);
    import memStagePkg::*;

    logic [1:0]                     isLoad;
    logic [1:0]                     misaligned;
    excCode_e [1:0]                 ownExc;
    logic [1:0][DATA_W-1:0]         alignedData;
    logic [1:0][DATA_W/8-1:0]       laneStrobe;

    for (genvar i = 0; i < 2; i++) begin : gSlot
        storeAlign uAlign (
            .op         (slotOp[i]),
            .byteOffset (slotAddr[i][1:0]),
            .storeData  (slotStoreData[i]),
            .wdata      (alignedData[i]),
            .strobe     (laneStrobe[i])
        );
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            isLoad[i]     = 1'b0;
            misaligned[i] = 1'b0;
            case (slotOp[i])
                MOP_LB, MOP_LBU: begin
                    isLoad[i] = 1'b1;
                end
                MOP_LH, MOP_LHU: begin
                    isLoad[i]     = 1'b1;
                    misaligned[i] = slotAddr[i][0];
                end
                MOP_LW: begin
                    isLoad[i]     = 1'b1;
                    misaligned[i] = |slotAddr[i][1:0];
                end
                MOP_SH: begin
                    misaligned[i] = slotAddr[i][0];
                end
                MOP_SW: begin
                    misaligned[i] = |slotAddr[i][1:0];
                end
                default: begin
                    misaligned[i] = 1'b0;
                end
            endcase

            // tlb fault wins over misalignment
            if (slotOp[i] == MOP_NONE) begin
                ownExc[i] = EXC_NONE;
            end else if (slotTlbExc[i] != TLB_NONE) begin
                ownExc[i] = isLoad[i] ? EXC_TLBL : EXC_TLBS;
            end else if (misaligned[i]) begin
                ownExc[i] = isLoad[i] ? EXC_ADEL : EXC_ADES;
            end else begin
                ownExc[i] = EXC_NONE;
            end
        end

        // older slot 1 kills younger slot 0, never the reverse
        excCode[1] = ownExc[1];
        if (ownExc[0] == EXC_NONE && ownExc[1] != EXC_NONE) begin
            excCode[0] = EXC_SQUASHED;
        end else begin
            excCode[0] = ownExc[0];
        end

        for (int i = 0; i < 2; i++) begin
            req[i].doAccess = (slotOp[i] != MOP_NONE) && (excCode[i] == EXC_NONE);
            req[i].isLoad   = isLoad[i];
            req[i].op       = slotOp[i];
            req[i].addr     = slotAddr[i];
            req[i].wdata    = alignedData[i];
            req[i].strobe   = laneStrobe[i];
            req[i].regWrite = req[i].doAccess && isLoad[i];
            req[i].rdst     = slotRdst[i];
        end

        excp = (ownExc[1] != EXC_NONE) || (ownExc[0] != EXC_NONE);
    end

endmodule

//--- src/dbusSequencer.sv
`timescale 1ns/1ps

module dbusSequencer (
    input  logic                                    clk,
    input  logic                                    arstN,
    input  logic                                    inReq,
    output logic                                    inAck,
    input  memStagePkg::memReq_t [1:0]              req,
    dbusIf.master                                   bus,
    output logic [1:0]                              wbRegWrite,
    output logic [1:0][4:0]                         wbRdst,
    output logic [1:0][memStagePkg::DATA_W-1:0]     wbData
);
    import memStagePkg::*;

    seqState_e              state;
    logic                   curSlot;
    logic                   busReq;
    logic [DATA_W-1:0]      loadValue;
    logic [1:0][DATA_W-1:0] loadData;

    loadExtend uExtend (
        .op         (req[curSlot].op),
        .byteOffset (req[curSlot].addr[1:0]),
        .rdata      (bus.rdata),
        .loadValue  (loadValue)
    );

    // request fields stay stable for the whole transaction
    assign bus.req    = busReq;
    assign bus.addr   = req[curSlot].addr;
    assign bus.wdata  = req[curSlot].wdata;
    assign bus.strobe = req[curSlot].strobe;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= IDLE;
            curSlot <= 1'b1;
            busReq  <= 1'b0;
            inAck   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (inReq) begin
                        // older slot goes first
                        if (req[1].doAccess) begin
                            curSlot <= 1'b1;
                            busReq  <= 1'b1;
                            state   <= BUS_REQ;
                        end else if (req[0].doAccess) begin
                            curSlot <= 1'b0;
                            busReq  <= 1'b1;
                            state   <= BUS_REQ;
                        end else begin
                            inAck <= 1'b1;
                            state <= DONE;
                        end
                    end
                end
                BUS_REQ: begin
                    if (bus.ack) begin
                        busReq <= 1'b0;
                        state  <= BUS_RELEASE;
                    end
                end
                BUS_RELEASE: begin
                    // wait for ack low before next req
                    if (!bus.ack) begin
                        if (curSlot && req[0].doAccess) begin
                            curSlot <= 1'b0;
                            busReq  <= 1'b1;
                            state   <= BUS_REQ;
                        end else begin
                            inAck <= 1'b1;
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // capture extended load data while rdata is valid
    always_ff @(posedge clk) begin
        if (state == BUS_REQ && bus.ack && req[curSlot].isLoad) begin
            loadData[curSlot] <= loadValue;
        end
    end

    for (genvar i = 0; i < 2; i++) begin : gWb
        assign wbRegWrite[i] = req[i].regWrite;
        assign wbRdst[i]     = req[i].rdst;
        assign wbData[i]     = req[i].regWrite ? loadData[i] : '0;
    end

endmodule

//--- src/dataRam.sv
`timescale 1ns/1ps

module dataRam (
    input  logic    clk,
    input  logic    arstN,
    dbusIf.slave    bus
);
    import memStagePkg::*;

    logic [DATA_W-1:0]  mem [MEM_WORDS];
    logic [MEM_AW-1:0]  wordAddr;
    logic               accept;
    logic               ackQ;
    logic [DATA_W-1:0]  rdataQ;

    // upper address bits fall outside the RAM
    assign wordAddr = bus.addr[MEM_AW+1:2];

    // one access per req, taken while ack is still low
    assign accept = bus.req && !ackQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ackQ <= 1'b0;
        end else if (accept) begin
            ackQ <= 1'b1;
        end else if (!bus.req) begin
            ackQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (bus.strobe[b]) begin
                    mem[wordAddr][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
            // read returns the word before this write
            rdataQ <= mem[wordAddr];
        end
    end

    assign bus.ack   = ackQ;
    assign bus.rdata = rdataQ;

endmodule

//--- src/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            inReq,
    output logic                            inAck,
    input  memStagePkg::memOp_e             op0,
    input  memStagePkg::memOp_e             op1,
    input  logic [memStagePkg::DATA_W-1:0]  addr0,
    input  logic [memStagePkg::DATA_W-1:0]  addr1,
    input  logic [memStagePkg::DATA_W-1:0]  storeData0,
    input  logic [memStagePkg::DATA_W-1:0]  storeData1,
    input  logic [4:0]                      rdst0,
    input  logic [4:0]                      rdst1,
    input  memStagePkg::tlbExc_e            tlbExc0,
    input  memStagePkg::tlbExc_e            tlbExc1,
    output logic                            wbRegWrite0,
    output logic                            wbRegWrite1,
    output logic [4:0]                      wbRdst0,
    output logic [4:0]                      wbRdst1,
    output logic [memStagePkg::DATA_W-1:0]  wbData0,
    output logic [memStagePkg::DATA_W-1:0]  wbData1,
    output memStagePkg::excCode_e           excCode0,
    output memStagePkg::excCode_e           excCode1,
    output logic                            excp
);
    import memStagePkg::*;

    memOp_e [1:0]           slotOp;
    logic [1:0][DATA_W-1:0] slotAddr;
    logic [1:0][DATA_W-1:0] slotStoreData;
    logic [1:0][4:0]        slotRdst;
    tlbExc_e [1:0]          slotTlbExc;
    memReq_t [1:0]          slotReq;
    excCode_e [1:0]         slotExc;
    logic [1:0]             wbRegWrite;
    logic [1:0][4:0]        wbRdst;
    logic [1:0][DATA_W-1:0] wbData;

    dbusIf dbus ();

    // plain ports to slot arrays, index 1 is the older slot
    assign slotOp[1]        = op1;
    assign slotOp[0]        = op0;
    assign slotAddr[1]      = addr1;
    assign slotAddr[0]      = addr0;
    assign slotStoreData[1] = storeData1;
    assign slotStoreData[0] = storeData0;
    assign slotRdst[1]      = rdst1;
    assign slotRdst[0]      = rdst0;
    assign slotTlbExc[1]    = tlbExc1;
    assign slotTlbExc[0]    = tlbExc0;

    assign wbRegWrite1 = wbRegWrite[1];
    assign wbRegWrite0 = wbRegWrite[0];
    assign wbRdst1     = wbRdst[1];
    assign wbRdst0     = wbRdst[0];
    assign wbData1     = wbData[1];
    assign wbData0     = wbData[0];
    assign excCode1    = slotExc[1];
    assign excCode0    = slotExc[0];

    memAccess uAccess (
        .slotOp        (slotOp),
        .slotAddr      (slotAddr),
        .slotStoreData (slotStoreData),
        .slotRdst      (slotRdst),
        .slotTlbExc    (slotTlbExc),
        .req           (slotReq),
        .excCode       (slotExc),
        .excp          (excp)
    );

    dbusSequencer uSequencer (
        .clk        (clk),
        .arstN      (arstN),
        .inReq      (inReq),
        .inAck      (inAck),
        .req        (slotReq),
        .bus        (dbus.master),
        .wbRegWrite (wbRegWrite),
        .wbRdst     (wbRdst),
        .wbData     (wbData)
    );

    dataRam uRam (
        .clk   (clk),
        .arstN (arstN),
        .bus   (dbus.slave)
    );

endmodule

//--- bench/memSubsystem_asserts.sv
`timescale 1ns/1ps

module memSubsystem_asserts (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            inReq,
    input  logic                            inAck,
    input  logic                            busReq,
    input  logic                            busAck,
    input  logic [1:0]                      wbRegWrite,
    input  memStagePkg::excCode_e [1:0]     excCode
);
    import memStagePkg::*;

    // req stays up until the RAM answers
    assert property (@(posedge clk) disable iff (!arstN) busReq && !busAck |=> busReq)
        else $error("bus req dropped before ack");

    assert property (@(posedge clk) disable iff (!arstN) $rose(busAck) |-> $past(busReq))
        else $error("bus ack rose without req");

    assert property (@(posedge clk) disable iff (!arstN) $rose(inAck) |-> $past(inReq))
        else $error("inAck rose without inReq");

    // faulted or squashed slots never write back
    assert property (@(posedge clk) disable iff (!arstN)
        wbRegWrite[1] |-> excCode[1] == EXC_NONE)
        else $error("slot 1 writes back despite an exception");

    assert property (@(posedge clk) disable iff (!arstN)
        wbRegWrite[0] |-> excCode[0] == EXC_NONE)
        else $error("slot 0 writes back despite an exception");

endmodule

bind memSubsystem memSubsystem_asserts uAsserts (
    .clk        (clk),
    .arstN      (arstN),
    .inReq      (inReq),
    .inAck      (inAck),
    .busReq     (dbus.req),
    .busAck     (dbus.ack),
    .wbRegWrite (wbRegWrite),
    .excCode    (slotExc)
);

//--- bench/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;
    import memStagePkg::*;

    localparam int          WAIT_LIMIT = 20;
    localparam logic [32:0] FROM_MODEL = 33'h1_0000_0000;
    localparam logic [32:0] NO_DATA    = 33'h0_0000_0000;

    // one slot of a table row
    // exp bit 32 picks the reference model value over exp[31:0]
    typedef struct packed {
        memOp_e      op;
        logic [31:0] addr;
        logic [31:0] sd;
        tlbExc_e     tlb;
        excCode_e    exc;
        logic [32:0] exp;
    } slot_t;

    logic                 clk = 1'b0;
    logic                 arstN;
    logic                 inReq;
    logic                 inAck;
    memOp_e               op0, op1;
    logic [DATA_W-1:0]    addr0, addr1, storeData0, storeData1;
    logic [4:0]           rdst0, rdst1, wbRdst0, wbRdst1;
    tlbExc_e              tlbExc0, tlbExc1;
    logic                 wbRegWrite0, wbRegWrite1, excp;
    logic [DATA_W-1:0]    wbData0, wbData1;
    excCode_e             excCode0, excCode1;

    logic [DATA_W-1:0]    refMem [MEM_WORDS];
    slot_t                tblOld[$];
    slot_t                tblYoung[$];
    string                tblName[$];
    int                   seed = 32'h62a9_0afb;

    memSubsystem DUT (
        .clk         (clk),
        .arstN       (arstN),
        .inReq       (inReq),
        .inAck       (inAck),
        .op0         (op0),
        .op1         (op1),
        .addr0       (addr0),
        .addr1       (addr1),
        .storeData0  (storeData0),
        .storeData1  (storeData1),
        .rdst0       (rdst0),
        .rdst1       (rdst1),
        .tlbExc0     (tlbExc0),
        .tlbExc1     (tlbExc1),
        .wbRegWrite0 (wbRegWrite0),
        .wbRegWrite1 (wbRegWrite1),
        .wbRdst0     (wbRdst0),
        .wbRdst1     (wbRdst1),
        .wbData0     (wbData0),
        .wbData1     (wbData1),
        .excCode0    (excCode0),
        .excCode1    (excCode1),
        .excp        (excp)
    );

    always #20 clk = ~clk;

    task automatic checkWord(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "data value mismatch");
        end
    endtask

    task automatic checkExc(input string name, input excCode_e exp, input excCode_e act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
            $display("TB FAILED");
            $fatal(1, "exception code mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic checkRdst(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "destination register mismatch");
        end
    endtask

    task automatic waitAck(input logic level, input string name);
        int n;
        n = 0;
        while (inAck !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (inAck !== level) begin
            $display("TB FAILED");
            $fatal(1, "inAck did not reach %b in time during %s", level, name);
        end
    endtask

    function automatic logic isLoad(input memOp_e op);
        return op inside {MOP_LB, MOP_LBU, MOP_LH, MOP_LHU, MOP_LW};
    endfunction

    // start contents mix every address bit
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};
    endfunction

    // faulted or squashed slots leave the reference memory alone
    task automatic modelSlot(input slot_t s, output logic [31:0] val);
        logic [MEM_AW-1:0] idx;
        logic [4:0]        sh;
        logic [31:0]       w;
        logic [7:0]        b;
        logic [15:0]       h;
        idx = s.addr[MEM_AW+1:2];
        sh  = {s.addr[1:0], 3'b000};
        w   = refMem[idx];
        b   = 8'(w >> sh);
        h   = 16'(w >> sh);
        val = 32'h0;
        if (s.exc == EXC_NONE) begin
            case (s.op)
                MOP_SB:  refMem[idx] = (w & ~(32'hFF << sh)) | ((s.sd & 32'hFF) << sh);
                MOP_SH:  refMem[idx] = (w & ~(32'hFFFF << sh)) | ((s.sd & 32'hFFFF) << sh);
                MOP_SW:  refMem[idx] = s.sd;
                MOP_LB:  val = {{24{b[7]}}, b};
                MOP_LBU: val = {24'h0, b};
                MOP_LH:  val = {{16{h[15]}}, h};
                MOP_LHU: val = {16'h0, h};
                MOP_LW:  val = w;
                default: val = 32'h0;
            endcase
        end
    endtask

    task automatic addRow(input string name,
        input memOp_e o1, input logic [31:0] a1, d1, input tlbExc_e t1,
        input excCode_e e1, input logic [32:0] x1,
        input memOp_e o0, input logic [31:0] a0, d0, input tlbExc_e t0,
        input excCode_e e0, input logic [32:0] x0);
        tblName.push_back(name);
        tblOld.push_back(slot_t'{o1, a1, d1, t1, e1, x1});
        tblYoung.push_back(slot_t'{o0, a0, d0, t0, e0, x0});
    endtask

    task automatic runPair(input string name, input slot_t s1, input slot_t s0, input int idx);
        logic [31:0] val1, val0, exp1, exp0;
        logic        wr1, wr0;
        @(negedge clk);
        op1        = s1.op;
        addr1      = s1.addr;
        storeData1 = s1.sd;
        tlbExc1    = s1.tlb;
        rdst1      = 5'(2 * idx + 1);
        op0        = s0.op;
        addr0      = s0.addr;
        storeData0 = s0.sd;
        tlbExc0    = s0.tlb;
        rdst0      = 5'(2 * idx);
        inReq      = 1'b1;
        // older slot touches the model first
        modelSlot(s1, val1);
        modelSlot(s0, val0);
        wr1  = isLoad(s1.op) && (s1.exc == EXC_NONE);
        wr0  = isLoad(s0.op) && (s0.exc == EXC_NONE);
        exp1 = !wr1 ? 32'h0 : (s1.exp[32] ? val1 : s1.exp[31:0]);
        exp0 = !wr0 ? 32'h0 : (s0.exp[32] ? val0 : s0.exp[31:0]);
        waitAck(1'b1, name);
        checkExc({name, " excCode1"}, s1.exc, excCode1);
        checkExc({name, " excCode0"}, s0.exc, excCode0);
        checkBit({name, " excp"}, (s1.exc != EXC_NONE) || (s0.exc != EXC_NONE), excp);
        checkBit({name, " wbRegWrite1"}, wr1, wbRegWrite1);
        checkBit({name, " wbRegWrite0"}, wr0, wbRegWrite0);
        checkWord({name, " wbData1"}, exp1, wbData1);
        checkWord({name, " wbData0"}, exp0, wbData0);
        checkRdst({name, " wbRdst1"}, rdst1, wbRdst1);
        checkRdst({name, " wbRdst0"}, rdst0, wbRdst0);
        inReq = 1'b0;
        waitAck(1'b0, name);
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rd;
        arstN      = 1'b0;
        inReq      = 1'b0;
        op0        = MOP_NONE;
        op1        = MOP_NONE;
        addr0      = '0;
        addr1      = '0;
        storeData0 = '0;
        storeData1 = '0;
        rdst0      = '0;
        rdst1      = '0;
        tlbExc0    = TLB_NONE;
        tlbExc1    = TLB_NONE;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkBit("reset inAck", 1'b0, inAck);

        // words 0..31 get known contents two at a time
        for (int w = 0; w < 32; w += 2) begin
            runPair("fill",
                slot_t'{MOP_SW, 32'(w * 4), fillWord(32'(w * 4)), TLB_NONE, EXC_NONE, NO_DATA},
                slot_t'{MOP_SW, 32'(w * 4 + 4), fillWord(32'(w * 4 + 4)), TLB_NONE, EXC_NONE,
                        NO_DATA}, w);
        end

        addRow("order_sw_lw", MOP_SW, 32'h10, 32'hCAFE_F00D, TLB_NONE, EXC_NONE, NO_DATA,
               MOP_LW, 32'h10, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL);
        addRow("order_lw_sw", MOP_LW, 32'h14, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL,
               MOP_SW, 32'h14, 32'h1234_5678, TLB_NONE, EXC_NONE, NO_DATA);
        addRow("order_check", MOP_LW, 32'h14, 32'h0, TLB_NONE, EXC_NONE, 33'h0_1234_5678,
               MOP_LBU, 32'h17, 32'h0, TLB_NONE, EXC_NONE, 33'h0_0000_0012);
        addRow("sb_low", MOP_SB, 32'h20, 32'hDEAD_BEAA, TLB_NONE, EXC_NONE, NO_DATA,
               MOP_SB, 32'h21, 32'h1234_5655, TLB_NONE, EXC_NONE, NO_DATA);
        addRow("sb_high", MOP_SB, 32'h22, 32'h0000_0080, TLB_NONE, EXC_NONE, NO_DATA,
               MOP_SB, 32'h23, 32'hFFFF_FF7F, TLB_NONE, EXC_NONE, NO_DATA);
        addRow("sb_check", MOP_LW, 32'h20, 32'h0, TLB_NONE, EXC_NONE, 33'h0_7F80_55AA,
               MOP_LB, 32'h22, 32'h0, TLB_NONE, EXC_NONE, 33'h0_FFFF_FF80);
        addRow("sh_lanes", MOP_SH, 32'h24, 32'h1111_8001, TLB_NONE, EXC_NONE, NO_DATA,
               MOP_SH, 32'h2A, 32'hFFFF_7FFE, TLB_NONE, EXC_NONE, NO_DATA);
        addRow("sh_merge", MOP_LW, 32'h24, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL,
               MOP_LW, 32'h28, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL);
        addRow("sh_extend", MOP_LH, 32'h24, 32'h0, TLB_NONE, EXC_NONE, 33'h0_FFFF_8001,
               MOP_LHU, 32'h2A, 32'h0, TLB_NONE, EXC_NONE, 33'h0_0000_7FFE);
        addRow("fill_bytes", MOP_LB, 32'h31, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL,
               MOP_LBU, 32'h33, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL);
        addRow("fill_halves", MOP_LH, 32'h36, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL,
               MOP_LHU, 32'h3A, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL);
        addRow("misalign_load", MOP_LH, 32'h41, 32'h0, TLB_NONE, EXC_ADEL, NO_DATA,
               MOP_LW, 32'h46, 32'h0, TLB_NONE, EXC_ADEL, NO_DATA);
        addRow("misalign_store", MOP_SW, 32'h4A, 32'hBAD0_BAD0, TLB_NONE, EXC_ADES, NO_DATA,
               MOP_SW, 32'h4C, 32'hBAD1_BAD1, TLB_NONE, EXC_SQUASHED, NO_DATA);
        addRow("misalign_young", MOP_LW, 32'h48, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL,
               MOP_SH, 32'h4D, 32'hBAD2_BAD2, TLB_NONE, EXC_ADES, NO_DATA);
        addRow("unchanged", MOP_LW, 32'h48, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL,
               MOP_LW, 32'h4C, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL);
        addRow("tlb_load", MOP_LW, 32'h51, 32'h0, TLB_REFILL, EXC_TLBL, NO_DATA,
               MOP_LB, 32'h50, 32'h0, TLB_NONE, EXC_SQUASHED, NO_DATA);
        addRow("tlb_young", MOP_SW, 32'h54, 32'h0F0F_0F0F, TLB_NONE, EXC_NONE, NO_DATA,
               MOP_SH, 32'h57, 32'hBAD3_BAD3, TLB_INVALID, EXC_TLBS, NO_DATA);
        addRow("tlb_check", MOP_LW, 32'h54, 32'h0, TLB_NONE, EXC_NONE, 33'h0_0F0F_0F0F,
               MOP_LHU, 32'h56, 32'h0, TLB_NONE, EXC_NONE, 33'h0_0000_0F0F);
        addRow("no_access", MOP_NONE, 32'h0, 32'h0, TLB_NONE, EXC_NONE, NO_DATA,
               MOP_NONE, 32'h0, 32'h0, TLB_NONE, EXC_NONE, NO_DATA);

        foreach (tblName[i]) begin
            runPair(tblName[i], tblOld[i], tblYoung[i], i);
        end

        // random SW/LW pairs on words 0..31 with random upper address bits
        for (int k = 0; k < 40; k++) begin
            ra = $random(seed);
            rb = $random(seed);
            rd = $random(seed);
            ra = {ra[31:10], 3'b000, ra[6:2], 2'b00};
            rb = {rb[31:10], 3'b000, rb[6:2], 2'b00};
            if (k % 2 == 0) begin
                rb[9:2] = ra[9:2];
            end
            runPair($sformatf("random_%0d", k),
                slot_t'{MOP_SW, ra, rd, TLB_NONE, EXC_NONE, NO_DATA},
                slot_t'{MOP_LW, rb, 32'h0, TLB_NONE, EXC_NONE, FROM_MODEL}, k);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- memSubsystem.f
src/memStagePkg.sv
src/dbusIf.sv
src/storeAlign.sv
src/loadExtend.sv
src/memAccess.sv
src/dbusSequencer.sv
src/dataRam.sv
src/memSubsystem.sv
bench/memSubsystem_asserts.sv
bench/memSubsystemTb.sv

//--- Makefile
VERILATOR := verilator
TOP       := memSubsystemTb
FILELIST  := memSubsystem.f
OBJDIR    := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
